//--- project.f
+incdir+dv
design/spi_pkg.sv
design/spi_pin_sync.sv
design/spi_bit_counter.sv
design/spi_frame_fsm.sv
design/spi_shift_path.sv
design/spi_slave_top.sv
dv/spi_slave_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
  -f project.f --top-module spi_slave_tb -o sim_spi_slave &&
./obj_dir/sim_spi_slave | tee /dev/stderr | grep -q "test passed" ||
{ echo "simulation did not pass"; exit 1; }

//--- dv/spi_master_tasks.svh
`ifndef spi_master_tasks_svh
`define spi_master_tasks_svh

// SPI master in mode 0 with all pin changes on falling clk edges

// pull select low with sck idle and wait out the setup time
task automatic select_begin();
  sck    = 1'b0;
  ssel_n = 1'b0;
  repeat (sel_setup) @(negedge clk);
endtask

// hold after the last fall then release select and leave the bus idle
task automatic select_end();
  repeat (sel_hold) @(negedge clk);
  ssel_n = 1'b1;
  mosi   = 1'b0;
  repeat (sel_hold) @(negedge clk);   // idle gap long enough for frame_error
endtask

// shift nbits msb first and return what the slave drove on miso
task automatic shift_bits(input byte_t data, input int nbits, output byte_t seen);
  seen = '0;
  for (int i = 0; i < nbits; i++)
  begin
    mosi = data[spi_pkg::byte_width-1-i];  // data changes with the sck fall
    repeat (half_period) @(negedge clk);
    seen[spi_pkg::byte_width-1-i] = miso;  // just before the rise
    sck = 1'b1;                            // slave samples mosi here
    repeat (half_period) @(negedge clk);
    sck = 1'b0;                            // slave shifts or reloads tx
  end
endtask

`endif

//--- dv/spi_slave_tb.sv
`timescale 1ns/100ps

module spi_slave_tb;

  localparam int sync_stages = 3;
  localparam int count_width = 8;
  localparam int half_period = 6;   // sck half period in clk cycles
  localparam int sel_setup   = 6;   // select low before the first rise
  localparam int sel_hold    = 6;   // after the last fall and as the idle gap
  localparam int n_single    = 20;
  localparam int n_multi     = 16;
  localparam int n_partial   = 10;  // each one followed by a clean frame
  localparam int max_bytes   = 4;
  localparam int n_frames    = n_single + n_multi + 2 * n_partial;
  // worst frame is max_bytes bytes of 8 bits at 12 cycles per bit plus select timing
  localparam int frame_cycles = max_bytes * spi_pkg::byte_width * 2 * half_period
                                + sel_setup + 2 * sel_hold;
  localparam int timeout_cycles = n_frames * frame_cycles + 200;  // margin covers reset

  typedef logic [spi_pkg::byte_width-1:0] byte_t;
  typedef logic [count_width-1:0]         count_t;

  logic   clk;
  logic   arst_n;
  logic   sck;
  logic   ssel_n;
  logic   mosi;
  byte_t  tx_byte;
  logic   miso;
  byte_t  rx_byte;
  logic   byte_valid;
  logic   frame_error;
  count_t frame_count;

  byte_t rx_expect[$];        // bytes the master shifted in with the strobe pending
  byte_t tx_expect[$];        // tx_byte values in the order they go out on miso
  int    frames_started = 0;  // model frame counter
  int    cycle_count = 0;
  int    n_errors = 0;
  logic  err_seen;            // frame_error seen since the frame began
  string test_name = "reset";

  spi_slave_top #(
    .sync_stages (sync_stages),
    .count_width (count_width)
  ) dut (
    .clk         (clk),
    .arst_n      (arst_n),
    .sck         (sck),
    .ssel_n      (ssel_n),
    .mosi        (mosi),
    .tx_byte     (tx_byte),
    .miso        (miso),
    .rx_byte     (rx_byte),
    .byte_valid  (byte_valid),
    .frame_error (frame_error),
    .frame_count (frame_count)
  );

  always #10 clk = ~clk;  // 20 ns period

  `include "spi_master_tasks.svh"

  task automatic fail_run(input string msg);
    n_errors++;
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic compare_byte(input string what, input byte_t exp, input byte_t act);
    if (act !== exp)
      fail_run($sformatf("ERROR %s %s: expected %02h, actual %02h",
                         test_name, what, exp, act));
  endtask

  task automatic compare_count(input string what, input count_t exp, input count_t act);
    if (act !== exp)
      fail_run($sformatf("ERROR %s %s: expected %0d, actual %0d",
                         test_name, what, exp, act));
  endtask

  task automatic compare_flag(input string what, input logic exp, input logic act);
    if (act !== exp)
      fail_run($sformatf("ERROR %s %s: expected %b, actual %b",
                         test_name, what, exp, act));
  endtask

  task automatic compare_state(input string what, input spi_pkg::frame_state_t exp,
                               input spi_pkg::frame_state_t act);
    if (act !== exp)
      fail_run($sformatf("ERROR %s %s: expected %s, actual %s",
                         test_name, what, exp.name(), act.name()));
  endtask

  // one frame of nbytes full bytes, then tail_bits of a partial byte
  task automatic run_frame(input int nbytes, input int tail_bits);
    byte_t data;
    byte_t seen;
    byte_t mask;
    err_seen = 1'b0;
    frames_started++;
    select_begin();
    for (int b = 0; b < nbytes; b++)
    begin
      data = byte_t'($urandom());
      rx_expect.push_back(data);
      shift_bits(data, spi_pkg::byte_width, seen);
      compare_byte("miso byte", tx_expect.pop_front(), seen);  // strobe already pushed the next
    end
    if (tail_bits > 0)
    begin
      data = byte_t'($urandom());
      shift_bits(data, tail_bits, seen);
      mask = '1;
      mask = mask << (spi_pkg::byte_width - tail_bits);  // only the bits clocked out
      compare_byte("miso partial", tx_expect[0] & mask, seen);
    end
    select_end();
    if (rx_expect.size() != 0)
      fail_run("a byte sent by the master never came out on rx_byte");
    compare_count("frame_count", count_t'(frames_started), frame_count);  // wraps at count_width bits
    compare_flag("frame_error", tail_bits > 0, err_seen);
    compare_state("state", spi_pkg::idle, dut.state);
  endtask

  // byte strobes and frame errors watched on every falling edge
  always @(negedge clk)
  begin
    if (arst_n)
    begin
      if (byte_valid)
      begin
        tx_byte = byte_t'($urandom());  // held until the next strobe
        tx_expect.push_back(tx_byte);
        if (rx_expect.size() == 0)
          fail_run("byte_valid pulsed with no full byte sent by the master");
        else
          compare_byte("rx_byte", rx_expect.pop_front(), rx_byte);
      end
      if (frame_error)
      begin
        if (err_seen)
          fail_run("frame_error pulsed more than once in one frame");
        else
          err_seen = 1'b1;
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count > timeout_cycles)
      fail_run("timeout, the run did not finish within the cycle limit");
  end

  initial
  begin
    void'($urandom(32'h3456));  // seeds the whole run
    clk      = 1'b0;
    arst_n   = 1'b0;
    sck      = 1'b0;
    ssel_n   = 1'b1;
    mosi     = 1'b0;
    err_seen = 1'b0;
    tx_byte  = byte_t'($urandom());
    tx_expect.push_back(tx_byte);    // loaded at the first select fall
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    compare_flag("byte_valid", 1'b0, byte_valid);
    compare_flag("frame_error", 1'b0, frame_error);
    compare_count("frame_count", count_t'(0), frame_count);
    compare_flag("miso", 1'b0, miso);
    compare_state("state", spi_pkg::idle, dut.state);

    test_name = "single_byte";
    repeat (n_single) run_frame(1, 0);
    test_name = "multi_byte";
    repeat (n_multi) run_frame($urandom_range(max_bytes, 2), 0);
    test_name = "partial_byte";
    repeat (n_partial)
    begin
      run_frame($urandom_range(1, 0), $urandom_range(spi_pkg::byte_width - 1, 1));
      run_frame(1, 0);               // next full frame comes through clean
    end

    if (n_errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

//--- design/spi_slave_top.sv
`timescale 1ns/100ps

module spi_slave_top #(
  parameter int sync_stages = 3,
  parameter int count_width = 8
) (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            sck,
  input  logic                            ssel_n,
  input  logic                            mosi,
  input  logic [spi_pkg::byte_width-1:0]  tx_byte,
  output logic                            miso,
  output logic [spi_pkg::byte_width-1:0]  rx_byte,
  output logic                            byte_valid,
  output logic                            frame_error,
  output logic [count_width-1:0]          frame_count
);

  spi_pkg::spi_events_t  events;
  spi_pkg::frame_state_t state;   // observed by the testbench

  logic bit_inc;
  logic count_clr;
  logic last_bit;
  logic mid_byte;
  logic sample_en;
  logic byte_done;
  logic shift_out_en;
  logic tx_load;

  spi_pin_sync #(
    .sync_stages (sync_stages)
  ) u_pin_sync (
    .clk    (clk),
    .arst_n (arst_n),
    .sck    (sck),
    .ssel_n (ssel_n),
    .mosi   (mosi),
    .events (events)
  );

  spi_bit_counter u_bit_counter (
    .clk       (clk),
    .arst_n    (arst_n),
    .count_clr (count_clr),
    .bit_inc   (bit_inc),
    .last_bit  (last_bit),
    .mid_byte  (mid_byte)
  );

  spi_frame_fsm #(
    .count_width (count_width)
  ) u_frame_fsm (
    .clk          (clk),
    .arst_n       (arst_n),
    .events       (events),
    .last_bit     (last_bit),
    .mid_byte     (mid_byte),
    .bit_inc      (bit_inc),
    .count_clr    (count_clr),
    .sample_en    (sample_en),
    .byte_done    (byte_done),
    .shift_out_en (shift_out_en),
    .tx_load      (tx_load),
    .byte_valid   (byte_valid),
    .frame_error  (frame_error),
    .frame_count  (frame_count),
    .state        (state)
  );

  spi_shift_path u_shift_path (
    .clk          (clk),
    .arst_n       (arst_n),
    .events       (events),
    .sample_en    (sample_en),
    .byte_done    (byte_done),
    .shift_out_en (shift_out_en),
    .tx_load      (tx_load),
    .tx_byte      (tx_byte),
    .rx_byte      (rx_byte),
    .miso         (miso)
  );

endmodule

//--- design/spi_shift_path.sv
`timescale 1ns/100ps

module spi_shift_path (
  input  logic                            clk,
  input  logic                            arst_n,
  input  spi_pkg::spi_events_t            events,
  input  logic                            sample_en,
  input  logic                            byte_done,
  input  logic                            shift_out_en,
  input  logic                            tx_load,
  input  logic [spi_pkg::byte_width-1:0]  tx_byte,
  output logic [spi_pkg::byte_width-1:0]  rx_byte,
  output logic                            miso
);

  logic [spi_pkg::byte_width-1:0] rx_shift;  // msb first receive
  logic [spi_pkg::byte_width-1:0] rx_next;   // shift value incl the current bit
  logic [spi_pkg::byte_width-1:0] tx_shift;  // msb drives miso

  assign rx_next = {rx_shift[spi_pkg::byte_width-2:0], events.mosi_bit};

  // receive shift and holding registers
  always_ff @(posedge clk)
  begin
    if (sample_en)
    begin
      rx_shift <= rx_next;
      if (byte_done)
        rx_byte <= rx_next;  // hold until the next full byte
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      tx_shift <= '0;        // miso low out of reset
    else if (tx_load)
      tx_shift <= tx_byte;   // only sampled here
    else if (shift_out_en)
      tx_shift <= {tx_shift[spi_pkg::byte_width-2:0], 1'b0};
  end

  // single slave so miso is never released
  assign miso = tx_shift[spi_pkg::byte_width-1];

endmodule

//--- design/spi_frame_fsm.sv
`timescale 1ns/100ps

module spi_frame_fsm #(
  parameter int count_width = 8
) (
  input  logic                      clk,
  input  logic                      arst_n,
  input  spi_pkg::spi_events_t      events,
  input  logic                      last_bit,
  input  logic                      mid_byte,
  output logic                      bit_inc,
  output logic                      count_clr,
  output logic                      sample_en,
  output logic                      byte_done,
  output logic                      shift_out_en,
  output logic                      tx_load,
  output logic                      byte_valid,
  output logic                      frame_error,
  output logic [count_width-1:0]    frame_count,
  output spi_pkg::frame_state_t     state
);

  logic in_frame;      // shifting with select still low
  logic byte_pending;  // a byte finished so the next fall reloads tx

  assign in_frame = (state == spi_pkg::shifting) && events.sel_active;

  // controls straight from state and events
  always_comb
  begin
    count_clr    = ~events.sel_active;
    bit_inc      = in_frame & events.sck_rise;
    sample_en    = bit_inc;                  // every sampled bit enters rx
    byte_done    = bit_inc & last_bit;       // eighth bit of a byte
    // reload on frame start or first fall after a completed byte
    tx_load      = events.sel_start | (in_frame & events.sck_fall & byte_pending);
    shift_out_en = in_frame & events.sck_fall & ~byte_pending & ~events.sel_start;
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state        <= spi_pkg::idle;
      byte_pending <= 1'b0;
      byte_valid   <= 1'b0;
      frame_error  <= 1'b0;
      frame_count  <= '0;
    end
    else
    begin
      case (state)
        spi_pkg::idle:     if (events.sel_start) state <= spi_pkg::shifting;
        spi_pkg::shifting: if (events.sel_end) state <= spi_pkg::idle;
        default:           state <= spi_pkg::idle;
      endcase
      if (events.sel_start || tx_load)
        byte_pending <= 1'b0;      // new frame or reload consumed it
      else if (byte_done)
        byte_pending <= 1'b1;
      byte_valid  <= byte_done;    // one-cycle strobe in step with rx_byte
      // partial byte when select rises with bits in the counter
      frame_error <= (state == spi_pkg::shifting) & events.sel_end & mid_byte;
      if (events.sel_start)
        frame_count <= frame_count + count_width'(1);  // wraps
    end
  end

  a_valid_in_frame : assert property (@(posedge clk) disable iff (!arst_n)
    byte_valid |-> (state == spi_pkg::shifting) || $past(state == spi_pkg::shifting));

  a_load_shift_excl : assert property (@(posedge clk) disable iff (!arst_n)
    !(tx_load && shift_out_en));

endmodule

//--- design/spi_bit_counter.sv
`timescale 1ns/100ps

module spi_bit_counter (
  input  logic clk,
  input  logic arst_n,
  input  logic count_clr,
  input  logic bit_inc,
  output logic last_bit,
  output logic mid_byte
);

  localparam int cnt_width = $clog2(spi_pkg::byte_width);

  logic [cnt_width-1:0] bit_cnt;  // bit position inside the current byte

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      bit_cnt <= '0;
    else if (count_clr)
      bit_cnt <= '0;            // clear wins while select is inactive
    else if (bit_inc)
    begin
      if (last_bit)
        bit_cnt <= '0;          // wrap at the byte boundary
      else
        bit_cnt <= bit_cnt + cnt_width'(1);
    end
  end

  assign last_bit = (bit_cnt == cnt_width'(spi_pkg::byte_width - 1));
  assign mid_byte = (bit_cnt != '0);  // some bits of a byte already taken

  // the FSM only counts bits while the select is held so these never meet
  a_inc_clr_excl : assert property (@(posedge clk) disable iff (!arst_n)
    !(bit_inc && count_clr));

endmodule

//--- design/spi_pin_sync.sv
`timescale 1ns/100ps

module spi_pin_sync #(
  parameter int sync_stages = 3
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                sck,
  input  logic                ssel_n,
  input  logic                mosi,
  output spi_pkg::spi_events_t events
);

  // index 0 is the newest stage and sync_stages-1 the oldest
  logic [sync_stages-1:0] sck_q;
  logic [sync_stages-1:0] ssel_q;
  logic [sync_stages-1:0] mosi_q;

  logic sck_old;
  logic sck_new;
  logic sel_old;
  logic sel_new;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sck_q  <= '0;  // sck idles low in mode 0
      ssel_q <= '1;  // deselected
      mosi_q <= '0;
    end
    else
    begin
      sck_q  <= {sck_q[sync_stages-2:0], sck};
      ssel_q <= {ssel_q[sync_stages-2:0], ssel_n};
      mosi_q <= {mosi_q[sync_stages-2:0], mosi};
    end
  end

  // edge detection on the two oldest stages
  assign sck_old = sck_q[sync_stages-1];
  assign sck_new = sck_q[sync_stages-2];
  assign sel_old = ssel_q[sync_stages-1];
  assign sel_new = ssel_q[sync_stages-2];

  always_comb
  begin
    events.sck_rise   = ~sck_old & sck_new;
    events.sck_fall   = sck_old & ~sck_new;
    events.sel_active = ~sel_new;           // active low pin
    events.sel_start  = sel_old & ~sel_new; // frame opens
    events.sel_end    = ~sel_old & sel_new; // frame closes
    // mosi taken at the same depth as sck_new so data lines up with the rise
    events.mosi_bit   = mosi_q[sync_stages-2];
  end

endmodule

//--- design/spi_pkg.sv
package spi_pkg;

  // bits per byte on the wire as frames are whole bytes
  localparam int byte_width = 8;

  // pin events in the clk domain
  typedef struct packed {
    logic sck_rise;   // sample point in mode 0
    logic sck_fall;   // shift-out point
    logic sel_active; // level while select is asserted
    logic sel_start;  // select falling edge
    logic sel_end;    // select rising edge
    logic mosi_bit;   // synchronized data at the same age as the sck edge
  } spi_events_t;

  // frame tracking
  typedef enum logic {
    idle,      // no frame on the bus
    shifting   // select low, bits moving
  } frame_state_t;

endpackage
